// File: hdl/vc_pkg.sv
package vc_pkg;

	localparam int VC_WAYS        = 4;
	localparam int VC_OFFSET_BITS = 4;
	localparam int VC_TAG_BITS    = 12;
	localparam int VC_LINE_BITS   = 128;
	localparam int VC_ADDR_BITS   = VC_TAG_BITS + VC_OFFSET_BITS;
	localparam int VC_WAY_BITS    = $clog2(VC_WAYS);

	// upper address bits that name a line
	typedef logic [VC_TAG_BITS-1:0]  vc_tag_t;

	typedef logic [VC_LINE_BITS-1:0] vc_line_t;

	// byte address on the L2 side
	typedef logic [VC_ADDR_BITS-1:0] vc_addr_t;

	typedef logic [VC_WAY_BITS-1:0]  vc_way_t;

	// request payload from L1, held stable by L1 until ack
	typedef struct packed {
		logic     we;    // 1 = insert evicted line, 0 = lookup
		vc_tag_t  tag;
		vc_line_t line;
		logic     dirty;
	} vc_l1_req_t;

	// read response to L1, valid in the ack cycle
	typedef struct packed {
		vc_line_t line;
		logic     dirty;
	} vc_l1_rsp_t;

endpackage

// File: hdl/vc_slot_array.sv
`timescale 1ns/10ps

module vc_slot_array (
	input  logic              clk,
	input  logic              rst,
	input  vc_pkg::vc_tag_t   tag,
	input  vc_pkg::vc_way_t   way,
	input  logic              write,
	input  logic              inval,
	input  logic              wr_dirty,
	input  vc_pkg::vc_tag_t   wr_tag,
	input  vc_pkg::vc_line_t  wr_line,
	output logic              hit,
	output vc_pkg::vc_way_t   hit_way,
	output logic              full,
	output logic [vc_pkg::VC_WAYS-1:0] valid,
	output logic [vc_pkg::VC_WAYS-1:0] dirty,
	output vc_pkg::vc_tag_t   tags [vc_pkg::VC_WAYS],
	output vc_pkg::vc_line_t  lines [vc_pkg::VC_WAYS]
);

	import vc_pkg::*;

	logic [VC_WAYS-1:0] hit_vec;

	// valid bits are the only control state in the array
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (write) begin
			valid[way] <= 1'b1;
		end else if (inval) begin
			valid[way] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (write) begin
			tags[way]  <= wr_tag;
			lines[way] <= wr_line;
			dirty[way] <= wr_dirty;
		end
	end

	// parallel compare against every valid entry
	always_comb begin
		for (int i = 0; i < VC_WAYS; i++) begin
			hit_vec[i] = valid[i] && (tags[i] == tag);
		end
	end

	always_comb begin
		hit_way = '0;
		for (int i = 0; i < VC_WAYS; i++) begin
			if (hit_vec[i]) begin
				hit_way = vc_way_t'(i);
			end
		end
	end

	assign hit  = |hit_vec;
	assign full = &valid;   // no free slot left

	// an insert always reuses the entry that already holds its tag,
	// so the same tag can never sit in two ways
	a_single_hit : assert property (@(posedge clk) disable iff (rst)
		$onehot0(hit_vec));

endmodule

// File: hdl/vc_lru_tracker.sv
`timescale 1ns/10ps

module vc_lru_tracker (
	input  logic            clk,
	input  logic            rst,
	input  logic            touch,
	input  vc_pkg::vc_way_t way,
	output vc_pkg::vc_way_t lru_way
);

	import vc_pkg::*;

	logic [1:0] rank [VC_WAYS];   // 3 = most recent, 0 = next to go
	logic [VC_WAYS-1:0] rank_seen;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < VC_WAYS; i++) begin
				rank[i] <= 2'(i);   // way 0 starts as LRU
			end
		end else if (touch) begin
			for (int i = 0; i < VC_WAYS; i++) begin
				if (vc_way_t'(i) == way) begin
					rank[i] <= 2'd3;
				end else if (rank[i] > rank[way]) begin
					rank[i] <= rank[i] - 2'd1;
				end
			end
		end
	end

	always_comb begin
		lru_way = '0;
		for (int i = 0; i < VC_WAYS; i++) begin
			if (rank[i] == 2'd0) begin
				lru_way = vc_way_t'(i);
			end
		end
	end

	// each rank value must be held by exactly one way
	always_comb begin
		rank_seen = '0;
		for (int i = 0; i < VC_WAYS; i++) begin
			rank_seen[rank[i]] = 1'b1;
		end
	end

	a_rank_perm : assert property (@(posedge clk) disable iff (rst)
		rank_seen == '1);

endmodule

// File: hdl/vc_datapath.sv
`timescale 1ns/10ps

module vc_datapath (
	input  logic               clk,
	input  logic               rst,
	input  vc_pkg::vc_l1_req_t req_in,
	input  logic               req_load,
	input  logic               rsp_load,
	input  logic               rsp_sel_fill,
	input  logic               adr_sel_victim,
	input  vc_pkg::vc_line_t   l2_rdat,
	input  logic               hit,
	input  logic               full,
	input  vc_pkg::vc_way_t    hit_way,
	input  vc_pkg::vc_way_t    lru_way,
	input  logic [vc_pkg::VC_WAYS-1:0] valid,
	input  logic [vc_pkg::VC_WAYS-1:0] dirty,
	input  vc_pkg::vc_tag_t    tags [vc_pkg::VC_WAYS],
	input  vc_pkg::vc_line_t   lines [vc_pkg::VC_WAYS],
	output vc_pkg::vc_l1_req_t req,
	output vc_pkg::vc_way_t    target_way,
	output logic               victim_dirty,
	output vc_pkg::vc_l1_rsp_t rsp,
	output vc_pkg::vc_addr_t   l2_adr,
	output vc_pkg::vc_line_t   l2_wdat
);

	import vc_pkg::*;

	vc_way_t    free_way;
	vc_tag_t    victim_tag;
	vc_line_t   victim_line;
	vc_tag_t    l2_tag;
	vc_l1_rsp_t rsp_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			req <= '0;
		end else if (req_load) begin
			req <= req_in;
		end
	end

	// lowest numbered empty way
	always_comb begin
		free_way = '0;
		for (int i = VC_WAYS - 1; i >= 0; i--) begin
			if (!valid[i]) begin
				free_way = vc_way_t'(i);
			end
		end
	end

	always_comb begin
		if (hit) begin
			target_way = hit_way;
		end else if (!full) begin
			target_way = free_way;
		end else begin
			target_way = lru_way;
		end
	end

	assign victim_tag  = tags[target_way];
	assign victim_line = lines[target_way];
	assign victim_dirty = valid[target_way] && dirty[target_way] && (victim_tag != req.tag);

	always_comb begin
		if (rsp_sel_fill) begin
			rsp_next = '{line: l2_rdat, dirty: 1'b0};   // a line from L2 is clean
		end else begin
			rsp_next = '{line: victim_line, dirty: dirty[target_way]};
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_load) begin
			rsp <= rsp_next;
		end
	end

	assign l2_tag  = adr_sel_victim ? victim_tag : req.tag;
	assign l2_adr  = {l2_tag, {VC_OFFSET_BITS{1'b0}}};
	assign l2_wdat = victim_line;

endmodule

// File: hdl/vc_control.sv
`timescale 1ns/10ps

module vc_control (
	input  logic               clk,
	input  logic               rst,
	input  logic               l1_cyc,
	input  logic               l1_stb,
	input  vc_pkg::vc_l1_req_t req,
	input  logic               hit,
	input  logic               victim_dirty,
	input  logic               l2_ack,
	output logic               l1_ack,
	output logic               l2_cyc,
	output logic               l2_stb,
	output logic               l2_we,
	output logic               req_load,
	output logic               rsp_load,
	output logic               rsp_sel_fill,
	output logic               adr_sel_victim,
	output logic               slot_write,
	output logic               slot_inval,
	output logic               lru_touch
);

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		WRITEBACK,
		FILL,
		RESPOND
	} state_t;

	state_t state, state_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next     = state;
		l1_ack         = 1'b0;
		l2_cyc         = 1'b0;
		l2_stb         = 1'b0;
		l2_we          = 1'b0;
		req_load       = 1'b0;
		rsp_load       = 1'b0;
		rsp_sel_fill   = 1'b0;
		adr_sel_victim = 1'b0;
		slot_write     = 1'b0;
		slot_inval     = 1'b0;
		lru_touch      = 1'b0;

		case (state)
			IDLE: begin
				if (l1_cyc && l1_stb) begin
					req_load   = 1'b1;
					state_next = LOOKUP;
				end
			end
			LOOKUP: begin
				if (req.we) begin
					state_next = victim_dirty ? WRITEBACK : RESPOND;
				end else if (hit) begin
					rsp_load   = 1'b1;   // line moves back to L1
					slot_inval = 1'b1;
					state_next = RESPOND;
				end else begin
					state_next = FILL;
				end
			end
			WRITEBACK: begin
				l2_cyc         = 1'b1;
				l2_stb         = 1'b1;
				l2_we          = 1'b1;
				adr_sel_victim = 1'b1;
				if (l2_ack) begin
					state_next = RESPOND;
				end
			end
			FILL: begin
				l2_cyc = 1'b1;
				l2_stb = 1'b1;
				if (l2_ack) begin
					rsp_load     = 1'b1;
					rsp_sel_fill = 1'b1;
					state_next   = RESPOND;
				end
			end
			RESPOND: begin
				l1_ack = 1'b1;
				if (req.we) begin
					slot_write = 1'b1;   // target way unchanged since lookup
					lru_touch  = 1'b1;
				end
				state_next = IDLE;
			end
			default: state_next = IDLE;
		endcase
	end

	// master side holds its strobe and direction until L2 answers
	a_l2_hold : assert property (@(posedge clk) disable iff (rst)
		(l2_stb && !l2_ack) |=> (l2_stb && l2_cyc && $stable(l2_we)));

	a_l1_ack_stb : assert property (@(posedge clk) disable iff (rst)
		l1_ack |-> l1_stb);

endmodule

// File: hdl/victim_cache.sv
`timescale 1ns/10ps

module victim_cache (
	input  logic               clk,
	input  logic               rst,
	input  logic               l1_cyc,
	input  logic               l1_stb,
	input  vc_pkg::vc_l1_req_t l1_req,
	output logic               l1_ack,
	output vc_pkg::vc_l1_rsp_t l1_rsp,
	output logic               l2_cyc,
	output logic               l2_stb,
	output logic               l2_we,
	output vc_pkg::vc_addr_t   l2_adr,
	output vc_pkg::vc_line_t   l2_wdat,
	input  logic               l2_ack,
	input  vc_pkg::vc_line_t   l2_rdat
);

	import vc_pkg::*;

	vc_l1_req_t req;
	vc_way_t    target_way, hit_way, lru_way;
	logic       hit, full, victim_dirty;
	logic       req_load, rsp_load, rsp_sel_fill, adr_sel_victim;
	logic       slot_write, slot_inval, lru_touch;
	logic [VC_WAYS-1:0] valid, dirty;
	vc_tag_t    tags [VC_WAYS];
	vc_line_t   lines [VC_WAYS];

	vc_slot_array u_slots (
		.clk, .rst,
		.tag(req.tag), .way(target_way),
		.write(slot_write), .inval(slot_inval),
		.wr_dirty(req.dirty), .wr_tag(req.tag), .wr_line(req.line),
		.hit, .hit_way, .full, .valid, .dirty, .tags, .lines
	);

	vc_lru_tracker u_lru (.clk, .rst, .touch(lru_touch), .way(target_way), .lru_way);

	vc_datapath u_dp (
		.clk, .rst, .req_in(l1_req), .req_load, .rsp_load, .rsp_sel_fill, .adr_sel_victim,
		.l2_rdat, .hit, .full, .hit_way, .lru_way, .valid, .dirty, .tags, .lines,
		.req, .target_way, .victim_dirty, .rsp(l1_rsp), .l2_adr, .l2_wdat
	);

	vc_control u_ctrl (
		.clk, .rst, .l1_cyc, .l1_stb, .req, .hit, .victim_dirty, .l2_ack,
		.l1_ack, .l2_cyc, .l2_stb, .l2_we, .req_load, .rsp_load, .rsp_sel_fill,
		.adr_sel_victim, .slot_write, .slot_inval, .lru_touch
	);

endmodule

// File: verif/victim_cache_tb.sv
`timescale 1ns/10ps

module victim_cache_tb;

	import vc_pkg::*;

	localparam int ACK_TIMEOUT = 60;

	typedef struct packed {
		logic       we;
		vc_tag_t    tag;
		vc_line_t   line;
		logic       dirty;
		vc_l1_rsp_t exp_rsp;   // reads only
		logic       exp_fill;
		logic       exp_wb;
		vc_addr_t   wb_adr;
		vc_line_t   wb_line;
	} op_row_t;

	logic       clk, rst, l1_cyc, l1_stb, l1_ack, l2_cyc, l2_stb, l2_we, l2_ack;
	vc_l1_req_t l1_req;
	vc_l1_rsp_t l1_rsp;
	vc_addr_t   l2_adr;
	vc_line_t   l2_wdat, l2_rdat;

	op_row_t  ops [$];
	vc_line_t l2_mem [vc_addr_t];
	vc_addr_t rd_adr_q [$];
	vc_addr_t wr_adr_q [$];
	vc_line_t wr_line_q [$];
	int       l2_delay [64];
	int       l2_n = 0;
	int       l2_wait = -1;
	int       err_count = 0;
	int       check_count = 0;

	// reference model of the four entries and their age ranks
	logic     m_valid [VC_WAYS];
	logic     m_dirty [VC_WAYS];
	vc_tag_t  m_tag [VC_WAYS];
	vc_line_t m_line [VC_WAYS];
	int       m_rank [VC_WAYS];
	vc_line_t m_mem [vc_addr_t];

	victim_cache DUT (.*);

	always #10 clk = ~clk;

	function automatic vc_addr_t tag_addr(input vc_tag_t tag);
		return {tag, {VC_OFFSET_BITS{1'b0}}};
	endfunction

	// unwritten L2 lines read back as their own address
	function automatic vc_line_t addr_pattern(input vc_addr_t adr);
		return {8{adr}};
	endfunction

	function automatic vc_line_t test_line(input logic [15:0] n);
		return {16'hDA7A, n, 32'h0F0F_0000 | n, ~{16'h5EED, n}, 16'hC0DE, ~n};
	endfunction

	// L2 slave, acks after a drawn delay of 0 to 3 cycles
	always @(posedge clk) begin
		if (rst) begin
			l2_ack <= 1'b0;
			l2_wait = -1;
		end else if (l2_ack) begin
			l2_ack <= 1'b0;
		end else if (l2_cyc && l2_stb) begin
			if (l2_wait < 0) begin
				l2_wait = l2_delay[l2_n % 64];
				l2_n = l2_n + 1;
			end
			if (l2_wait == 0) begin
				l2_wait = -1;
				l2_ack <= 1'b1;
				if (l2_we) begin
					l2_mem[l2_adr] = l2_wdat;
					wr_adr_q.push_back(l2_adr);
					wr_line_q.push_back(l2_wdat);
				end else begin
					rd_adr_q.push_back(l2_adr);
					l2_rdat <= l2_mem.exists(l2_adr) ? l2_mem[l2_adr] : addr_pattern(l2_adr);
				end
			end else begin
				l2_wait = l2_wait - 1;
			end
		end
	end

	task automatic add_op(input logic we, input vc_tag_t tag, input vc_line_t line,
			input logic dirty, input vc_l1_rsp_t exp_rsp, input logic fill,
			input logic wb, input vc_addr_t wb_adr, input vc_line_t wb_line);
		ops.push_back({we, tag, line, dirty, exp_rsp, fill, wb, wb_adr, wb_line});
	endtask

	task automatic build_table();
		add_op(1'b0, 12'h123, '0, 1'b0, {addr_pattern(16'h1230), 1'b0}, 1'b1, 1'b0, '0, '0);
		add_op(1'b1, 12'h010, test_line(1), 1'b1, '0, 1'b0, 1'b0, '0, '0);
		add_op(1'b0, 12'h010, '0, 1'b0, {test_line(1), 1'b1}, 1'b0, 1'b0, '0, '0);
		add_op(1'b0, 12'h010, '0, 1'b0, {addr_pattern(16'h0100), 1'b0}, 1'b1, 1'b0, '0, '0);
		add_op(1'b1, 12'h020, test_line(2), 1'b1, '0, 1'b0, 1'b0, '0, '0);
		add_op(1'b1, 12'h030, test_line(3), 1'b0, '0, 1'b0, 1'b0, '0, '0);
		add_op(1'b1, 12'h040, test_line(4), 1'b1, '0, 1'b0, 1'b0, '0, '0);
		add_op(1'b1, 12'h050, test_line(5), 1'b0, '0, 1'b0, 1'b0, '0, '0);
		add_op(1'b1, 12'h020, test_line(6), 1'b0, '0, 1'b0, 1'b0, '0, '0);   // overwrite, way 0 MRU
		add_op(1'b1, 12'h060, test_line(7), 1'b1, '0, 1'b0, 1'b0, '0, '0);   // clean LRU, way 1
		add_op(1'b1, 12'h070, test_line(8), 1'b0, '0, 1'b0, 1'b1, 16'h0400, test_line(4));
		add_op(1'b0, 12'h040, '0, 1'b0, {test_line(4), 1'b0}, 1'b1, 1'b0, '0, '0);
		add_op(1'b0, 12'h060, '0, 1'b0, {test_line(7), 1'b1}, 1'b0, 1'b0, '0, '0);
		add_op(1'b1, 12'h080, test_line(9), 1'b1, '0, 1'b0, 1'b0, '0, '0);
		add_op(1'b1, 12'h090, test_line(10), 1'b0, '0, 1'b0, 1'b0, '0, '0);
		add_op(1'b1, 12'h0A0, test_line(11), 1'b0, '0, 1'b0, 1'b0, '0, '0);
		add_op(1'b1, 12'h0B0, test_line(12), 1'b1, '0, 1'b0, 1'b0, '0, '0);
		add_op(1'b1, 12'h0C0, test_line(13), 1'b0, '0, 1'b0, 1'b1, 16'h0800, test_line(9));
		add_op(1'b0, 12'h0A0, '0, 1'b0, {test_line(11), 1'b0}, 1'b0, 1'b0, '0, '0);
		add_op(1'b0, 12'h050, '0, 1'b0, {addr_pattern(16'h0500), 1'b0}, 1'b1, 1'b0, '0, '0);
	endtask

	task automatic ref_step(input op_row_t op, output vc_l1_rsp_t rsp, output logic fill,
			output logic wb, output vc_addr_t wb_adr, output vc_line_t wb_line);
		int hit_w;
		int way;
		int old;
		hit_w = -1;
		rsp = '0;
		fill = 1'b0;
		wb = 1'b0;
		wb_adr = '0;
		wb_line = '0;
		for (int i = 0; i < VC_WAYS; i++) begin
			if (m_valid[i] && m_tag[i] == op.tag) begin
				hit_w = i;
			end
		end
		if (!op.we && hit_w >= 0) begin
			rsp = {m_line[hit_w], m_dirty[hit_w]};
			m_valid[hit_w] = 1'b0;   // line goes back to L1
		end else if (!op.we) begin
			fill = 1'b1;
			rsp.line = m_mem.exists(tag_addr(op.tag)) ? m_mem[tag_addr(op.tag)]
				: addr_pattern(tag_addr(op.tag));
		end else begin
			way = hit_w;
			for (int i = VC_WAYS - 1; i >= 0 && hit_w < 0; i--) begin
				if (!m_valid[i]) begin
					way = i;
				end
			end
			for (int i = 0; i < VC_WAYS && way < 0; i++) begin
				if (m_rank[i] == 0) begin
					way = i;
				end
			end
			if (m_valid[way] && m_dirty[way] && m_tag[way] != op.tag) begin
				wb = 1'b1;
				wb_adr = tag_addr(m_tag[way]);
				wb_line = m_line[way];
				m_mem[wb_adr] = wb_line;
			end
			m_valid[way] = 1'b1;
			m_tag[way] = op.tag;
			m_line[way] = op.line;
			m_dirty[way] = op.dirty;
			old = m_rank[way];
			for (int i = 0; i < VC_WAYS; i++) begin
				if (m_rank[i] > old) begin
					m_rank[i] = m_rank[i] - 1;
				end
			end
			m_rank[way] = 3;
		end
	endtask

	task automatic check_line(input string name, input vc_line_t got, input vc_line_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_rsp(input string name, input vc_l1_rsp_t got, input vc_l1_rsp_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Fail %s: got line %h dirty %h, expected line %h dirty %h",
				name, got.line, got.dirty, exp.line, exp.dirty);
		end
	endtask

	task automatic check_adr(input string name, input vc_addr_t got, input vc_addr_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic apply_op(input op_row_t op, output vc_l1_rsp_t rsp, output int cycles,
			output logic timed_out);
		@(posedge clk);
		l1_cyc <= 1'b1;
		l1_stb <= 1'b1;
		l1_req <= {op.we, op.tag, op.line, op.dirty};
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (!l1_ack && cycles < ACK_TIMEOUT);
		timed_out = !l1_ack;
		rsp = l1_rsp;
		l1_cyc <= 1'b0;
		l1_stb <= 1'b0;
	endtask

	task automatic check_row(input int idx, input op_row_t op, input vc_l1_rsp_t got,
			input int cycles);
		if (!op.we) begin
			check_rsp("l1_rsp", got, op.exp_rsp);
		end
		check_count++;
		if (rd_adr_q.size() != int'(op.exp_fill) || wr_adr_q.size() != int'(op.exp_wb)) begin
			err_count++;
			$display("row %0d: saw %0d L2 reads and %0d L2 writes, expected %0d and %0d",
				idx, rd_adr_q.size(), wr_adr_q.size(), op.exp_fill, op.exp_wb);
		end else begin
			if (op.exp_fill) begin
				check_adr("l2_adr", rd_adr_q[0], tag_addr(op.tag));
			end
			if (op.exp_wb) begin
				check_adr("l2_adr", wr_adr_q[0], op.wb_adr);
				check_line("l2_wdat", wr_line_q[0], op.wb_line);
			end
		end
		if (!op.exp_fill && !op.exp_wb && cycles != 3) begin   // ack due in cycle 2
			err_count++;
			$display("row %0d: l1_ack came in cycle %0d instead of cycle 2", idx, cycles - 1);
		end
	endtask

	initial begin
		int         cycles;
		logic       m_fill, m_wb, timed_out;
		vc_l1_rsp_t got, m_rsp;
		vc_addr_t   m_wb_adr;
		vc_line_t   m_wb_line;
		op_row_t    op;
		clk = 1'b0;
		rst = 1'b1;
		l1_cyc = 1'b0;
		l1_stb = 1'b0;
		l1_req = '0;
		l2_ack = 1'b0;
		l2_rdat = '0;
		void'($urandom(62159));
		for (int i = 0; i < 64; i++) begin
			l2_delay[i] = $urandom_range(3, 0);
		end
		for (int i = 0; i < VC_WAYS; i++) begin
			m_valid[i] = 1'b0;
			m_rank[i] = i;   // way 0 starts as LRU
		end
		build_table();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		if (l1_ack || l2_cyc || l2_stb || l2_we) begin
			err_count++;
			$display("bus outputs are not idle after reset");
		end
		timed_out = 1'b0;
		for (int i = 0; i < ops.size() && !timed_out; i++) begin
			op = ops[i];
			ref_step(op, m_rsp, m_fill, m_wb, m_wb_adr, m_wb_line);
			if ((!op.we && m_rsp !== op.exp_rsp) || m_fill !== op.exp_fill
					|| m_wb !== op.exp_wb
					|| (m_wb && {m_wb_adr, m_wb_line} !== {op.wb_adr, op.wb_line})) begin
				err_count++;
				$display("row %0d: reference model disagrees with the table", i);
			end
			rd_adr_q.delete();
			wr_adr_q.delete();
			wr_line_q.delete();
			apply_op(op, got, cycles, timed_out);
			if (timed_out) begin
				err_count++;
				$display("row %0d: no l1_ack within %0d cycles", i, ACK_TIMEOUT);
			end else begin
				check_row(i, op, got, cycles);
			end
		end
		$display("%0d rows, %0d checks, %0d errors", ops.size(), check_count, err_count);
		if (err_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: src.f
hdl/vc_pkg.sv
hdl/vc_slot_array.sv
hdl/vc_lru_tracker.sv
hdl/vc_datapath.sv
hdl/vc_control.sv
hdl/victim_cache.sv
verif/victim_cache_tb.sv

// File: Bender.yml
package:
  name: victim_cache

sources:
  - hdl/vc_pkg.sv
  - hdl/vc_slot_array.sv
  - hdl/vc_lru_tracker.sv
  - hdl/vc_datapath.sv
  - hdl/vc_control.sv
  - hdl/victim_cache.sv
  - target: test
    files:
      - verif/victim_cache_tb.sv
